//--- Bender.yml
package:
  name: cpu

sources:
  - logic/cpuPkg.sv
  - logic/alu.sv
  - logic/registerFile.sv
  - logic/dataPath.sv
  - logic/controlUnit.sv
  - logic/cpuTop.sv
  - target: test
    files:
      - tests/cpuTop_asserts.sv
      - tests/cpuTb.sv

//--- logic/alu.sv
// Arithmetic and logic unit
module alu (
    input  cpuPkg::aluOp_t  aluOp,
    input  cpuPkg::word_t   aluA,
    input  cpuPkg::word_t   aluB,
    output cpuPkg::word_t   aluResult
);

    logic [4:0]  shamt;
    logic [63:0] rolWide;
    logic [63:0] rorWide;

    assign shamt = aluB[4:0];

    // Rotates from a doubled copy of A
    assign rolWide = {aluA, aluA} << shamt;
    assign rorWide = {aluA, aluA} >> shamt;

    always_comb begin
        case (aluOp)
            cpuPkg::aluAdd:  aluResult = aluA + aluB;
            cpuPkg::aluSub:  aluResult = aluA - aluB;
            cpuPkg::aluAnd:  aluResult = aluA & aluB;
            cpuPkg::aluOr:   aluResult = aluA | aluB;
            cpuPkg::aluShl:  aluResult = aluA << shamt;
            cpuPkg::aluShr:  aluResult = aluA >> shamt;
            cpuPkg::aluShra: aluResult = $signed(aluA) >>> shamt;
            cpuPkg::aluRol:  aluResult = rolWide[63:32];
            cpuPkg::aluRor:  aluResult = rorWide[31:0];
            cpuPkg::aluNeg:  aluResult = -aluA;
            cpuPkg::aluNot:  aluResult = ~aluA;
            default:         aluResult = aluA;
        endcase
    end

endmodule

//--- logic/controlUnit.sv
// Control unit
// Fetch, decode and execute sequencing
module controlUnit (
    input  logic               clk,
    input  logic               reset,
    input  logic               stop,
    input  cpuPkg::opcode_t    opcode,
    output logic               run,
    output logic               marFromPc,
    output logic               incPc,
    output logic               memRead,
    output logic               memWrite,
    output logic               mdrLoad,
    output logic               irLoad,
    output logic               yLoad,
    output logic               zLoad,
    output logic               marFromZ,
    output logic               regWrite,
    output logic               outLoad,
    output logic               useConst,
    output logic               baseOut,
    output cpuPkg::aluOp_t     aluOp,
    output cpuPkg::writeSrc_t  writeSrc
);

    typedef enum logic [3:0] {
        stFetch0,
        stFetch1,
        stFetch2,
        stFetch3,
        stDecode,
        stExY,
        stExZ,
        stExWb,
        stExMar,
        stExRead,
        stExMdr,
        stExLdWb,
        stExWrite,
        stExIn,
        stExOut
    } state_t;

    state_t state;
    state_t nextState;
    logic   enable;
    logic   isLoad;
    logic   isMem;
    logic   constOp;
    logic   baseOp;

    // Opcode to ALU function
    function automatic cpuPkg::aluOp_t aluFor(input cpuPkg::opcode_t op);
        case (op)
            cpuPkg::opAdd, cpuPkg::opAddi, cpuPkg::opLdi,
            cpuPkg::opLd, cpuPkg::opSt:   return cpuPkg::aluAdd;
            cpuPkg::opSub:                return cpuPkg::aluSub;
            cpuPkg::opAnd, cpuPkg::opAndi: return cpuPkg::aluAnd;
            cpuPkg::opOr, cpuPkg::opOri:  return cpuPkg::aluOr;
            cpuPkg::opShl:                return cpuPkg::aluShl;
            cpuPkg::opShr:                return cpuPkg::aluShr;
            cpuPkg::opShra:               return cpuPkg::aluShra;
            cpuPkg::opRol:                return cpuPkg::aluRol;
            cpuPkg::opRor:                return cpuPkg::aluRor;
            cpuPkg::opNeg:                return cpuPkg::aluNeg;
            cpuPkg::opNot:                return cpuPkg::aluNot;
            default:                      return cpuPkg::aluPass;
        endcase
    endfunction

    // A state only acts in a cycle where it also advances
    assign enable = run && !stop;

    assign isLoad  = (opcode == cpuPkg::opLd);
    assign isMem   = isLoad || (opcode == cpuPkg::opSt);
    assign baseOp  = isMem || (opcode == cpuPkg::opLdi);
    assign constOp = baseOp || (opcode == cpuPkg::opAddi) ||
                     (opcode == cpuPkg::opAndi) || (opcode == cpuPkg::opOri);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            run <= 1'b0;
        end else begin
            run <= !stop;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= stFetch0;
        end else if (enable) begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = stFetch0;
        case (state)
            stFetch0: nextState = stFetch1;
            stFetch1: nextState = stFetch2;
            stFetch2: nextState = stFetch3;
            stFetch3: nextState = stDecode;
            stDecode: begin
                case (opcode)
                    cpuPkg::opIn:  nextState = stExIn;
                    cpuPkg::opOut: nextState = stExOut;
                    default: begin
                        // Unknown codes map to pass and go back to fetch
                        if (aluFor(opcode) != cpuPkg::aluPass) begin
                            nextState = stExY;
                        end
                    end
                endcase
            end
            stExY:    nextState = stExZ;
            stExZ:    nextState = isMem ? stExMar : stExWb;
            stExMar:  nextState = isLoad ? stExRead : stExWrite;
            stExRead: nextState = stExMdr;
            stExMdr:  nextState = stExLdWb;
            default:  nextState = stFetch0;
        endcase
    end

    // Strobes from the present state
    always_comb begin
        marFromPc = 1'b0;
        incPc     = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        mdrLoad   = 1'b0;
        irLoad    = 1'b0;
        yLoad     = 1'b0;
        zLoad     = 1'b0;
        marFromZ  = 1'b0;
        regWrite  = 1'b0;
        outLoad   = 1'b0;
        useConst  = 1'b0;
        baseOut   = 1'b0;
        aluOp     = cpuPkg::aluPass;
        writeSrc  = cpuPkg::fromZ;
        if (enable) begin
            case (state)
                stFetch0: begin
                    marFromPc = 1'b1;
                    incPc     = 1'b1;
                end
                stFetch1, stExRead: memRead = 1'b1;
                stFetch2, stExMdr:  mdrLoad = 1'b1;
                stFetch3: irLoad = 1'b1;
                stExY: begin
                    yLoad   = 1'b1;
                    baseOut = baseOp;
                end
                stExZ: begin
                    zLoad    = 1'b1;
                    useConst = constOp;
                    aluOp    = aluFor(opcode);
                end
                stExWb:   regWrite = 1'b1;
                stExMar:  marFromZ = 1'b1;
                stExLdWb: begin
                    regWrite = 1'b1;
                    writeSrc = cpuPkg::fromMdr;
                end
                stExWrite: memWrite = 1'b1;
                stExIn: begin
                    regWrite = 1'b1;
                    writeSrc = cpuPkg::fromInPort;
                end
                stExOut: outLoad = 1'b1;
                default: ;
            endcase
        end
    end

endmodule

//--- logic/cpuPkg.sv
// Processor shared definitions
package cpuPkg;

    localparam int wordWidth = 32;

    typedef logic [wordWidth-1:0] word_t;
    typedef logic [3:0] regAddr_t;

    // Instruction field positions
    localparam int opHi    = 31;
    localparam int opLo    = 27;
    localparam int raHi    = 26;
    localparam int raLo    = 23;
    localparam int rbHi    = 22;
    localparam int rbLo    = 19;
    localparam int rcHi    = 18;
    localparam int rcLo    = 15;
    localparam int constHi = 18;
    localparam int constLo = 0;

    // Encodings follow the original instruction set
    typedef enum logic [4:0] {
        opLd   = 5'd0,
        opLdi  = 5'd1,
        opSt   = 5'd2,
        opAdd  = 5'd3,
        opSub  = 5'd4,
        opAnd  = 5'd5,
        opOr   = 5'd6,
        opShr  = 5'd7,
        opShra = 5'd8,
        opShl  = 5'd9,
        opRor  = 5'd10,
        opRol  = 5'd11,
        opAddi = 5'd12,
        opAndi = 5'd13,
        opOri  = 5'd14,
        opNeg  = 5'd17,
        opNot  = 5'd18,
        opIn   = 5'd22,
        opOut  = 5'd23
    } opcode_t;

    typedef enum logic [3:0] {
        aluPass,
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluShl,
        aluShr,
        aluShra,
        aluRol,
        aluRor,
        aluNeg,
        aluNot
    } aluOp_t;

    // Register file write source
    typedef enum logic [1:0] {
        fromZ,
        fromMdr,
        fromInPort
    } writeSrc_t;

endpackage

//--- logic/cpuTop.sv
// Multi-cycle processor top level
module cpuTop (
    input  logic           clk,
    input  logic           reset,
    input  logic           stop,
    input  cpuPkg::word_t  inPort,
    input  cpuPkg::word_t  memRdata,
    output logic           run,
    output logic           memRead,
    output logic           memWrite,
    output logic           outStrobe,
    output cpuPkg::word_t  memAddr,
    output cpuPkg::word_t  memWdata,
    output cpuPkg::word_t  outPort
);

    // Control strobes
    logic marFromPc;
    logic incPc;
    logic mdrLoad;
    logic irLoad;
    logic yLoad;
    logic zLoad;
    logic marFromZ;
    logic regWrite;
    logic outLoad;
    logic useConst;
    logic baseOut;

    cpuPkg::aluOp_t    aluOp;
    cpuPkg::writeSrc_t writeSrc;
    cpuPkg::opcode_t   opcode;

    // Register file and ALU connections
    cpuPkg::regAddr_t raAddr;
    cpuPkg::regAddr_t rbAddr;
    cpuPkg::regAddr_t rcAddr;
    cpuPkg::word_t    raData;
    cpuPkg::word_t    rbData;
    cpuPkg::word_t    rcData;
    cpuPkg::word_t    writeData;
    cpuPkg::word_t    aluA;
    cpuPkg::word_t    aluB;
    cpuPkg::word_t    aluResult;

    controlUnit i_control (
        .clk       (clk),
        .reset     (reset),
        .stop      (stop),
        .opcode    (opcode),
        .run       (run),
        .marFromPc (marFromPc),
        .incPc     (incPc),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .mdrLoad   (mdrLoad),
        .irLoad    (irLoad),
        .yLoad     (yLoad),
        .zLoad     (zLoad),
        .marFromZ  (marFromZ),
        .regWrite  (regWrite),
        .outLoad   (outLoad),
        .useConst  (useConst),
        .baseOut   (baseOut),
        .aluOp     (aluOp),
        .writeSrc  (writeSrc)
    );

    dataPath i_dataPath (
        .clk       (clk),
        .reset     (reset),
        .marFromPc (marFromPc),
        .incPc     (incPc),
        .mdrLoad   (mdrLoad),
        .irLoad    (irLoad),
        .yLoad     (yLoad),
        .zLoad     (zLoad),
        .marFromZ  (marFromZ),
        .outLoad   (outLoad),
        .useConst  (useConst),
        .baseOut   (baseOut),
        .aluOp     (aluOp),
        .memRdata  (memRdata),
        .inPort    (inPort),
        .opcode    (opcode),
        .raAddr    (raAddr),
        .rbAddr    (rbAddr),
        .rcAddr    (rcAddr),
        .rbData    (rbData),
        .rcData    (rcData),
        .raData    (raData),
        .aluA      (aluA),
        .aluB      (aluB),
        .aluResult (aluResult),
        .writeData (writeData),
        .writeSrc  (writeSrc),
        .memAddr   (memAddr),
        .memWdata  (memWdata),
        .outPort   (outPort),
        .outStrobe (outStrobe)
    );

    registerFile i_regFile (
        .clk       (clk),
        .reset     (reset),
        .regWrite  (regWrite),
        .raAddr    (raAddr),
        .rbAddr    (rbAddr),
        .rcAddr    (rcAddr),
        .writeData (writeData),
        .raData    (raData),
        .rbData    (rbData),
        .rcData    (rcData)
    );

    alu i_alu (
        .aluOp     (aluOp),
        .aluA      (aluA),
        .aluB      (aluB),
        .aluResult (aluResult)
    );

endmodule

//--- logic/dataPath.sv
// Processor datapath registers
// Field extraction and operand selection
module dataPath (
    input  logic               clk,
    input  logic               reset,
    input  logic               marFromPc,
    input  logic               incPc,
    input  logic               mdrLoad,
    input  logic               irLoad,
    input  logic               yLoad,
    input  logic               zLoad,
    input  logic               marFromZ,
    input  logic               outLoad,
    input  logic               useConst,
    input  logic               baseOut,
    input  cpuPkg::aluOp_t     aluOp,
    input  cpuPkg::word_t      memRdata,
    input  cpuPkg::word_t      inPort,
    output cpuPkg::opcode_t    opcode,
    output cpuPkg::regAddr_t   raAddr,
    output cpuPkg::regAddr_t   rbAddr,
    output cpuPkg::regAddr_t   rcAddr,
    input  cpuPkg::word_t      rbData,
    input  cpuPkg::word_t      rcData,
    input  cpuPkg::word_t      raData,
    output cpuPkg::word_t      aluA,
    output cpuPkg::word_t      aluB,
    input  cpuPkg::word_t      aluResult,
    output cpuPkg::word_t      writeData,
    input  cpuPkg::writeSrc_t  writeSrc,
    output cpuPkg::word_t      memAddr,
    output cpuPkg::word_t      memWdata,
    output cpuPkg::word_t      outPort,
    output logic               outStrobe
);

    cpuPkg::word_t pc;
    cpuPkg::word_t ir;
    cpuPkg::word_t mar;
    cpuPkg::word_t mdr;
    cpuPkg::word_t y;
    cpuPkg::word_t z;
    cpuPkg::word_t constC;
    cpuPkg::word_t baseValue;
    logic          unaryOp;

    assign opcode = cpuPkg::opcode_t'(ir[cpuPkg::opHi:cpuPkg::opLo]);
    assign raAddr = ir[cpuPkg::raHi:cpuPkg::raLo];
    assign rbAddr = ir[cpuPkg::rbHi:cpuPkg::rbLo];
    assign rcAddr = ir[cpuPkg::rcHi:cpuPkg::rcLo];

    // Sign-extended constant C
    assign constC = {{(cpuPkg::wordWidth - cpuPkg::constHi - 1){ir[cpuPkg::constHi]}},
                     ir[cpuPkg::constHi:cpuPkg::constLo]};

    // R0 reads as zero when used as a base
    assign baseValue = (baseOut && rbAddr == '0) ? '0 : rbData;

    // neg and not take only Y, B is held at zero
    assign unaryOp = (aluOp == cpuPkg::aluNeg) || (aluOp == cpuPkg::aluNot);
    assign aluA    = y;
    assign aluB    = unaryOp ? '0 : (useConst ? constC : rcData);

    always_comb begin
        case (writeSrc)
            cpuPkg::fromMdr:    writeData = mdr;
            cpuPkg::fromInPort: writeData = inPort;
            default:            writeData = z;
        endcase
    end

    assign memAddr  = mar;
    assign memWdata = raData;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc        <= '0;
            ir        <= '0;
            outPort   <= '0;
            outStrobe <= 1'b0;
        end else begin
            if (incPc) begin
                pc <= pc + 1'b1;
            end
            if (irLoad) begin
                ir <= mdr;
            end
            if (outLoad) begin
                outPort <= raData;
            end
            outStrobe <= outLoad;
        end
    end

    always_ff @(posedge clk) begin
        if (marFromPc) begin
            mar <= pc;
        end else if (marFromZ) begin
            mar <= z;
        end
        if (mdrLoad) begin
            mdr <= memRdata;
        end
        if (yLoad) begin
            y <= baseValue;
        end
        if (zLoad) begin
            z <= aluResult;
        end
    end

endmodule

//--- logic/registerFile.sv
// General register file
module registerFile (
    input  logic              clk,
    input  logic              reset,
    input  logic              regWrite,
    input  cpuPkg::regAddr_t  raAddr,
    input  cpuPkg::regAddr_t  rbAddr,
    input  cpuPkg::regAddr_t  rcAddr,
    input  cpuPkg::word_t     writeData,
    output cpuPkg::word_t     raData,
    output cpuPkg::word_t     rbData,
    output cpuPkg::word_t     rcData
);

    cpuPkg::word_t regs [16];

    // Asynchronous reads
    assign raData = regs[raAddr];
    assign rbData = regs[rbAddr];
    assign rcData = regs[rcAddr];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite) begin
            regs[raAddr] <= writeData;
        end
    end

endmodule

//--- project.f
logic/cpuPkg.sv
logic/alu.sv
logic/registerFile.sv
logic/dataPath.sv
logic/controlUnit.sv
logic/cpuTop.sv
tests/cpuTop_asserts.sv
tests/cpuTb.sv

//--- tests/cpuTb.sv
// Processor testbench
// Memory model, programs, reference model and checks
module cpuTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int memDepth    = 256;
    localparam int resetCycles = 5;
    localparam int stopCycles  = 12;

    logic          clk;
    logic          reset;
    logic          stop;
    cpuPkg::word_t inPort;
    cpuPkg::word_t memRdata;
    logic          run;
    logic          memRead;
    logic          memWrite;
    logic          outStrobe;
    cpuPkg::word_t memAddr;
    cpuPkg::word_t memWdata;
    cpuPkg::word_t outPort;

    cpuPkg::word_t mem [memDepth];
    cpuPkg::word_t prog [$];
    cpuPkg::word_t expOut [$];
    cpuPkg::word_t expAddr [$];
    cpuPkg::word_t expData [$];

    logic [31:0] lfsr;
    string       currentTest;
    int          errors;
    int          testsRun;
    int          testsFailed;
    int          budgetCycles;
    int          cyclesUsed;
    logic        expectFetchZero;

    cpuTop i_dut (
        .clk       (clk),
        .reset     (reset),
        .stop      (stop),
        .inPort    (inPort),
        .memRdata  (memRdata),
        .run       (run),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .outStrobe (outStrobe),
        .memAddr   (memAddr),
        .memWdata  (memWdata),
        .outPort   (outPort)
    );

    always #2 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic nextBit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic cpuPkg::word_t randBits(input int n);
        cpuPkg::word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], nextBit()};
        end
        return v;
    endfunction

    function automatic cpuPkg::word_t encodeReg(input cpuPkg::opcode_t op,
                                                input cpuPkg::regAddr_t ra,
                                                input cpuPkg::regAddr_t rb,
                                                input cpuPkg::regAddr_t rc);
        return {op, ra, rb, rc, 15'b0};
    endfunction

    function automatic cpuPkg::word_t encodeImm(input cpuPkg::opcode_t op,
                                                input cpuPkg::regAddr_t ra,
                                                input cpuPkg::regAddr_t rb,
                                                input cpuPkg::word_t c);
        return {op, ra, rb, c[18:0]};
    endfunction

    // Unknown opcode 31 with the address in two places
    function automatic cpuPkg::word_t fillWord(input logic [7:0] a);
        return {5'h1f, 3'b000, a, 8'h5a, ~a};
    endfunction

    // Instruction level model of the program in prog
    function automatic void executeProgram(input cpuPkg::word_t inValue);
        cpuPkg::word_t    image [memDepth];
        cpuPkg::word_t    r [16];
        cpuPkg::word_t    ins;
        cpuPkg::word_t    c;
        cpuPkg::word_t    addr;
        cpuPkg::word_t    a;
        cpuPkg::word_t    b;
        cpuPkg::regAddr_t ra;
        cpuPkg::regAddr_t rb;
        logic [4:0]       s;
        cpuPkg::opcode_t  op;
        expOut.delete();
        expAddr.delete();
        expData.delete();
        for (int i = 0; i < memDepth; i++) begin
            image[i] = fillWord(8'(i));
        end
        for (int i = 0; i < prog.size(); i++) begin
            image[i] = prog[i];
        end
        for (int i = 0; i < 16; i++) begin
            r[i] = '0;
        end
        for (int pc = 0; pc < prog.size(); pc++) begin
            ins  = image[pc];
            op   = cpuPkg::opcode_t'(ins[cpuPkg::opHi:cpuPkg::opLo]);
            ra   = ins[cpuPkg::raHi:cpuPkg::raLo];
            rb   = ins[cpuPkg::rbHi:cpuPkg::rbLo];
            c    = {{13{ins[cpuPkg::constHi]}}, ins[cpuPkg::constHi:cpuPkg::constLo]};
            a    = r[rb];
            b    = r[ins[cpuPkg::rcHi:cpuPkg::rcLo]];
            s    = b[4:0];
            // ld, st and ldi see R0 as zero base
            addr = ((rb == 0) ? '0 : r[rb]) + c;
            case (op)
                cpuPkg::opLd:   r[ra] = image[addr[7:0]];
                cpuPkg::opLdi:  r[ra] = addr;
                cpuPkg::opSt: begin
                    image[addr[7:0]] = r[ra];
                    expAddr.push_back(addr);
                    expData.push_back(r[ra]);
                end
                cpuPkg::opAdd:  r[ra] = a + b;
                cpuPkg::opSub:  r[ra] = a - b;
                cpuPkg::opAnd:  r[ra] = a & b;
                cpuPkg::opOr:   r[ra] = a | b;
                cpuPkg::opShl:  r[ra] = a << s;
                cpuPkg::opShr:  r[ra] = a >> s;
                cpuPkg::opShra: r[ra] = $signed(a) >>> s;
                cpuPkg::opRol:  r[ra] = (a << s) | (a >> (6'd32 - s));
                cpuPkg::opRor:  r[ra] = (a >> s) | (a << (6'd32 - s));
                cpuPkg::opAddi: r[ra] = a + c;
                cpuPkg::opAndi: r[ra] = a & c;
                cpuPkg::opOri:  r[ra] = a | c;
                cpuPkg::opNeg:  r[ra] = 32'd0 - a;
                cpuPkg::opNot:  r[ra] = ~a;
                cpuPkg::opIn:   r[ra] = inValue;
                cpuPkg::opOut:  expOut.push_back(r[ra]);
                default: ;
            endcase
        end
    endfunction

    task automatic checkWord(input string what, input cpuPkg::word_t expected,
                             input cpuPkg::word_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", what, expected, actual);
            errors++;
        end
    endtask

    task automatic checkFlag(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %b, actual %b", what, expected, actual);
            errors++;
        end
    endtask

    // Instruction followed by an out of its Ra
    task automatic pushAndReport(input cpuPkg::word_t ins);
        prog.push_back(ins);
        prog.push_back(encodeReg(cpuPkg::opOut, ins[cpuPkg::raHi:cpuPkg::raLo], 4'd0, 4'd0));
    endtask

    task automatic buildAluProgram(input int rounds);
        prog.delete();
        for (int n = 0; n < rounds; n++) begin
            prog.push_back(encodeImm(cpuPkg::opLdi, 4'd1, 4'd0, randBits(19)));
            prog.push_back(encodeImm(cpuPkg::opLdi, 4'd2, 4'd0, randBits(19)));
            pushAndReport(encodeReg(cpuPkg::opAdd, 4'd3, 4'd1, 4'd2));
            pushAndReport(encodeReg(cpuPkg::opSub, 4'd3, 4'd1, 4'd2));
            pushAndReport(encodeReg(cpuPkg::opAnd, 4'd3, 4'd1, 4'd2));
            pushAndReport(encodeReg(cpuPkg::opOr, 4'd3, 4'd1, 4'd2));
            pushAndReport(encodeReg(cpuPkg::opShl, 4'd3, 4'd1, 4'd2));
            pushAndReport(encodeReg(cpuPkg::opShr, 4'd3, 4'd1, 4'd2));
            pushAndReport(encodeReg(cpuPkg::opShra, 4'd3, 4'd1, 4'd2));
            pushAndReport(encodeReg(cpuPkg::opRol, 4'd3, 4'd1, 4'd2));
            pushAndReport(encodeReg(cpuPkg::opRor, 4'd3, 4'd1, 4'd2));
            pushAndReport(encodeReg(cpuPkg::opNeg, 4'd4, 4'd1, 4'd0));
            pushAndReport(encodeReg(cpuPkg::opNot, 4'd5, 4'd1, 4'd0));
        end
    endtask

    task automatic buildImmProgram();
        cpuPkg::word_t negC;
        cpuPkg::word_t posC;
        prog.delete();
        negC = randBits(18) | 32'h0004_0000;
        posC = randBits(18);
        prog.push_back(encodeImm(cpuPkg::opLdi, 4'd1, 4'd0, randBits(19)));
        pushAndReport(encodeImm(cpuPkg::opAddi, 4'd2, 4'd1, negC));
        pushAndReport(encodeImm(cpuPkg::opAddi, 4'd2, 4'd1, posC));
        pushAndReport(encodeImm(cpuPkg::opAndi, 4'd3, 4'd1, negC));
        pushAndReport(encodeImm(cpuPkg::opAndi, 4'd3, 4'd1, posC));
        pushAndReport(encodeImm(cpuPkg::opOri, 4'd4, 4'd1, negC));
        pushAndReport(encodeImm(cpuPkg::opOri, 4'd4, 4'd1, posC));
    endtask

    task automatic buildMemProgram();
        prog.delete();
        prog.push_back(encodeImm(cpuPkg::opLdi, 4'd1, 4'd0, randBits(19)));
        prog.push_back(encodeImm(cpuPkg::opLdi, 4'd6, 4'd0, randBits(19)));
        prog.push_back(encodeImm(cpuPkg::opLdi, 4'd2, 4'd0, 200));
        // Nonzero R0 so the zero base shows
        prog.push_back(encodeImm(cpuPkg::opLdi, 4'd0, 4'd0, 7));
        prog.push_back(encodeImm(cpuPkg::opSt, 4'd1, 4'd2, 5));
        prog.push_back(encodeImm(cpuPkg::opSt, 4'd6, 4'd0, 230));
        prog.push_back(encodeImm(cpuPkg::opSt, 4'd6, 4'd2, -3));
        pushAndReport(encodeImm(cpuPkg::opLdi, 4'd7, 4'd2, 9));
        pushAndReport(encodeImm(cpuPkg::opLd, 4'd3, 4'd2, 5));
        pushAndReport(encodeImm(cpuPkg::opLd, 4'd4, 4'd0, 230));
        pushAndReport(encodeImm(cpuPkg::opLd, 4'd5, 4'd2, -3));
    endtask

    task automatic buildPortProgram();
        prog.delete();
        pushAndReport(encodeReg(cpuPkg::opIn, 4'd1, 4'd0, 4'd0));
        pushAndReport(encodeReg(cpuPkg::opIn, 4'd9, 4'd0, 4'd0));
        pushAndReport(encodeReg(cpuPkg::opAdd, 4'd10, 4'd1, 4'd9));
    endtask

    task automatic loadMemory();
        for (int a = 0; a < memDepth; a++) begin
            mem[a] = fillWord(8'(a));
        end
        for (int i = 0; i < prog.size(); i++) begin
            mem[i] = prog[i];
        end
    endtask

    // Reset, reload memory and the expected values, then watch run come up
    task automatic restartProgram(input cpuPkg::word_t inValue);
        @(posedge clk);
        reset  <= 1'b1;
        stop   <= 1'b0;
        inPort <= inValue;
        repeat (resetCycles) @(posedge clk);
        loadMemory();
        executeProgram(inValue);
        expectFetchZero = 1'b1;
        reset <= 1'b0;
        @(posedge clk);
        checkFlag({currentTest, " run one cycle after reset"}, 1'b0, run);
        @(posedge clk);
        checkFlag({currentTest, " run two cycles after reset"}, 1'b1, run);
    endtask

    task automatic runTest(input string name, input cpuPkg::word_t inValue,
                           input int stopAfter, input int resetAfterOuts);
        int errorsBefore;
        int outsTotal;
        errorsBefore = errors;
        currentTest  = name;
        budgetCycles = budgetCycles + 20 * prog.size() + 4 * resetCycles;
        if (stopAfter > 0) begin
            budgetCycles = budgetCycles + stopCycles;
        end
        if (resetAfterOuts > 0) begin
            budgetCycles = budgetCycles + 20 * prog.size() + 4 * resetCycles;
        end
        restartProgram(inValue);
        if (stopAfter > 0) begin
            repeat (stopAfter) @(posedge clk);
            stop <= 1'b1;
            repeat (stopCycles) @(posedge clk);
            checkFlag({name, " run during stop"}, 1'b0, run);
            stop <= 1'b0;
        end
        if (resetAfterOuts > 0) begin
            outsTotal = expOut.size();
            while (outsTotal - expOut.size() < resetAfterOuts) begin
                @(posedge clk);
            end
            restartProgram(inValue);
        end
        while (expOut.size() != 0 || expAddr.size() != 0) begin
            @(posedge clk);
        end
        testsRun++;
        if (errors != errorsBefore) begin
            testsFailed++;
        end
        $display("Test %s finished with %0d errors", name, errors - errorsBefore);
    endtask

    // Memory answers one cycle after the strobe
    always @(posedge clk) begin
        if (memRead) begin
            memRdata <= mem[memAddr[7:0]];
        end
        if (memWrite) begin
            mem[memAddr[7:0]] <= memWdata;
        end
    end

    // Compare outputs and stores against the reference model
    always @(posedge clk) begin
        if (!reset) begin
            if (outStrobe) begin
                if (expOut.size() == 0) begin
                    $display("Test %s: output %h appeared when none was expected",
                             currentTest, outPort);
                    errors++;
                end else begin
                    checkWord({currentTest, " outPort"}, expOut.pop_front(), outPort);
                end
            end
            if (memWrite) begin
                if (expAddr.size() == 0) begin
                    $display("Test %s: store to %h appeared when none was expected",
                             currentTest, memAddr);
                    errors++;
                end else begin
                    checkWord({currentTest, " store address"}, expAddr.pop_front(), memAddr);
                    checkWord({currentTest, " store data"}, expData.pop_front(), memWdata);
                end
            end
            if (memRead && expectFetchZero) begin
                checkWord({currentTest, " first fetch address"}, '0, memAddr);
                expectFetchZero = 1'b0;
            end
            if (stop) begin
                checkFlag({currentTest, " memRead while stopped"}, 1'b0, memRead);
                checkFlag({currentTest, " memWrite while stopped"}, 1'b0, memWrite);
                if (!run) begin
                    checkFlag({currentTest, " outStrobe while stopped"}, 1'b0, outStrobe);
                end
            end
        end
    end

    initial begin
        cyclesUsed = 0;
        while (cyclesUsed <= budgetCycles) begin
            @(posedge clk);
            cyclesUsed++;
        end
        $display("Watchdog: test %s stalled after %0d cycles", currentTest, cyclesUsed);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        clk             = 1'b0;
        reset           = 1'b1;
        stop            = 1'b0;
        inPort          = '0;
        memRdata        = '0;
        lfsr            = 32'h073d8d76;
        errors          = 0;
        testsRun        = 0;
        testsFailed     = 0;
        budgetCycles    = 0;
        expectFetchZero = 1'b0;
        currentTest     = "startup";

        buildAluProgram(2);
        runTest("aluOps", '0, 0, 0);
        buildImmProgram();
        runTest("immediates", '0, 0, 0);
        buildMemProgram();
        runTest("loadStore", '0, 0, 0);
        buildPortProgram();
        runTest("inOut", randBits(32), 0, 0);
        buildAluProgram(1);
        runTest("stopRun", '0, 60, 0);
        buildAluProgram(1);
        runTest("midReset", '0, 0, 4);

        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- tests/cpuTop_asserts.sv
// Processor strobe and run state assertions
module cpuTopAsserts (
    input logic clk,
    input logic reset,
    input logic run,
    input logic memRead,
    input logic memWrite,
    input logic outStrobe,
    input logic marFromPc,
    input logic incPc,
    input logic mdrLoad,
    input logic irLoad,
    input logic yLoad,
    input logic zLoad,
    input logic marFromZ,
    input logic regWrite,
    input logic outLoad
);
    timeunit 1ns;
    timeprecision 1ps;

    logic anyStrobe;

    assign anyStrobe = memRead | memWrite | outStrobe | marFromPc | incPc | mdrLoad |
                       irLoad | yLoad | zLoad | marFromZ | regWrite | outLoad;

    noReadWrite: assert property (@(posedge clk) disable iff (reset)
        !(memRead && memWrite))
        else $error("memRead and memWrite high in the same cycle");

    quietWhileStopped: assert property (@(posedge clk) disable iff (reset)
        !run |-> !anyStrobe)
        else $error("Strobe high while run is low");

    singleOutStrobe: assert property (@(posedge clk) disable iff (reset)
        outStrobe |=> !outStrobe)
        else $error("outStrobe held for two cycles");

    quietInReset: assert property (@(posedge clk)
        reset |-> !anyStrobe)
        else $error("Strobe high during reset");

endmodule

bind cpuTop cpuTopAsserts i_asserts (
    .clk       (clk),
    .reset     (reset),
    .run       (run),
    .memRead   (memRead),
    .memWrite  (memWrite),
    .outStrobe (outStrobe),
    .marFromPc (marFromPc),
    .incPc     (incPc),
    .mdrLoad   (mdrLoad),
    .irLoad    (irLoad),
    .yLoad     (yLoad),
    .zLoad     (zLoad),
    .marFromZ  (marFromZ),
    .regWrite  (regWrite),
    .outLoad   (outLoad)
);
